// ==== bench/oq_regs_assertions.sv ====
// Output queue register assertions
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_regs_assertions (
   input logic                          clk,
   input logic                          reset,
   input logic                          psel,
   input logic                          penable,
   input logic                          pwrite,
   input logic [`OQ_APB_ADDR_WIDTH-1:0] paddr,
   input logic [`OQ_DATA_WIDTH-1:0]     pwdata,
   input logic                          pready,
   input logic [`OQ_NUM_QUEUES-1:0]     queue_enable
);

   import oq_pkg::*;

   // The walk spends two cycles on every queue
   localparam int WALK_CYCLES = 2 * `OQ_NUM_QUEUES;

   int fail_count = 0;

   logic [`OQ_QUEUE_BITS-1:0] access_queue;
   logic                      init_access;

   assign access_queue = paddr[`OQ_QUEUE_MSB:`OQ_QUEUE_LSB];
   assign init_access  = psel && penable && pwrite && pwdata[`OQ_INIT_BIT]
                         && (paddr[`OQ_REG_MSB:`OQ_REG_LSB] == REG_CTRL);

   //////////////////////////////////////////////////////////////////////
   // APB completion

   pready_in_access: assert property (@(posedge clk) disable iff (reset)
      pready |-> (psel && penable))
   else begin
      fail_count++;
      $error("pready high outside an APB access phase");
   end

   pready_single: assert property (@(posedge clk) disable iff (reset)
      pready |=> !pready)
   else begin
      fail_count++;
      $error("pready high for two cycles in a row");
   end

   //////////////////////////////////////////////////////////////////////
   // Queue enables

   // No queue may send before the walk has loaded its defaults
   enable_off_in_walk: assert property (@(posedge clk)
      $fell(reset) |-> (queue_enable == '0) [*WALK_CYCLES])
   else begin
      fail_count++;
      $error("queue_enable set while the walk was still running");
   end

   enable_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(queue_enable))
   else begin
      fail_count++;
      $error("queue_enable has unknown bits after reset");
   end

   // The queue stays disabled until its clear has been acknowledged
   init_holds_disable: assert property (@(posedge clk) disable iff (reset)
      (pready && init_access) |->
         (!$past(queue_enable[access_queue]) && !$past(queue_enable[access_queue], 2)))
   else begin
      fail_count++;
      $error("queue_enable set while its queue was being initialized");
   end

endmodule

bind oq_regs_top oq_regs_assertions oq_regs_assertions_i (
   .clk          (clk),
   .reset        (reset),
   .psel         (psel),
   .penable      (penable),
   .pwrite       (pwrite),
   .paddr        (paddr),
   .pwdata       (pwdata),
   .pready       (pready),
   .queue_enable (queue_enable)
);

// ==== bench/oq_regs_tb.sv ====
// Output queue register testbench
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_regs_tb;

   import oq_pkg::*;

   localparam int CLK_PERIOD  = 8;
   localparam int NUM_REGS    = 11;
   localparam int SWEEP       = `OQ_NUM_QUEUES * NUM_REGS;
   localparam int NUM_RAND    = 24;
   localparam int WALK_CYCLES = 2 * `OQ_NUM_QUEUES;

   // Transfers of tests 1 to 5, in order
   localparam int TRANSFERS   = (1 + SWEEP) + 4 * NUM_RAND + 8 + (32 + SWEEP) + (10 + SWEEP);
   localparam int LIMIT       = TRANSFERS * 20 + WALK_CYCLES + 16;

   localparam oq_reg_e WRITABLE [5] = '{REG_ADDR_HI, REG_ADDR_LO, REG_MAX_PKTS,
                                        REG_PKTS_STORED, REG_PKTS_DROPPED};
   localparam oq_reg_e READ_ONLY [5] = '{REG_WR_ADDR, REG_RD_ADDR, REG_PKTS_IN_Q,
                                         REG_WORDS_IN_Q, REG_WORDS_LEFT};

   logic                          clk;
   logic                          reset;
   logic                          psel;
   logic                          penable;
   logic                          pwrite;
   logic [`OQ_APB_ADDR_WIDTH-1:0] paddr;
   logic [`OQ_DATA_WIDTH-1:0]     pwdata;
   logic [`OQ_DATA_WIDTH-1:0]     prdata;
   logic                          pready;
   logic [`OQ_NUM_QUEUES-1:0]     queue_enable;

   // Expected register contents
   logic [31:0]               model_reg [`OQ_NUM_QUEUES][NUM_REGS];
   logic [`OQ_NUM_QUEUES-1:0] model_en;

   logic [31:0] lcg_state;
   int          errors;
   int          test_num;
   int          test_errors;

   oq_regs_top oq_regs_top_i (
      .clk          (clk),
      .reset        (reset),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .queue_enable (queue_enable)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Register model

   function automatic void model_defaults();
      logic [31:0] lo;
      for (int q = 0; q < `OQ_NUM_QUEUES; q++) begin
         lo = q * `OQ_QUEUE_WORDS;
         for (int r = 0; r < NUM_REGS; r++) begin
            model_reg[q][r] = '0;
         end
         model_reg[q][REG_ADDR_LO]    = lo;
         model_reg[q][REG_ADDR_HI]    = lo + `OQ_QUEUE_WORDS - 1;
         model_reg[q][REG_WR_ADDR]    = lo;
         model_reg[q][REG_RD_ADDR]    = lo;
         model_reg[q][REG_MAX_PKTS]   = `OQ_DEFAULT_MAX_PKTS;
         model_reg[q][REG_WORDS_LEFT] = `OQ_QUEUE_WORDS;
      end
      model_en = '1;
   endfunction

   function automatic void model_write(input logic [2:0] q, input logic [3:0] off,
                                       input logic [31:0] data);
      case (off)
         REG_CTRL: begin
            if (data[`OQ_INIT_BIT]) begin
               model_reg[q][REG_WR_ADDR]      = model_reg[q][REG_ADDR_LO];
               model_reg[q][REG_RD_ADDR]      = model_reg[q][REG_ADDR_LO];
               model_reg[q][REG_WORDS_LEFT]   = model_reg[q][REG_ADDR_HI]
                                                - model_reg[q][REG_ADDR_LO] + 1;
               model_reg[q][REG_PKTS_IN_Q]    = '0;
               model_reg[q][REG_WORDS_IN_Q]   = '0;
               model_reg[q][REG_PKTS_STORED]  = '0;
               model_reg[q][REG_PKTS_DROPPED] = '0;
            end
            model_en[q] = data[`OQ_ENABLE_BIT];
         end
         REG_ADDR_HI, REG_ADDR_LO: begin
            model_reg[q][off] = 32'(data[`OQ_SRAM_ADDR_WIDTH-1:0]);
         end
         REG_MAX_PKTS, REG_PKTS_STORED, REG_PKTS_DROPPED: begin
            model_reg[q][off] = data;
         end
         default: ;
      endcase
   endfunction

   function automatic logic [31:0] expected_value(input logic [2:0] q, input logic [3:0] off);
      if (off == REG_CTRL) begin
         return 32'(model_en[q]);
      end
      if (off > REG_PKTS_DROPPED) begin
         return `OQ_UNMAPPED_DATA;
      end
      return model_reg[q][off];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // APB access and checks

   task automatic apb_transfer(input logic write, input logic [2:0] q, input logic [3:0] off,
                               input logic [31:0] wdata, output logic [31:0] rdata);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= {q, off, 2'b00};
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      // Wait states until pready
      do begin
         @(posedge clk);
      end while (!pready);
      rdata = prdata;
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_reg(input logic [2:0] q, input logic [3:0] off, input logic [31:0] data);
      logic [31:0] discard;
      apb_transfer(1'b1, q, off, data, discard);
      model_write(q, off, data);
   endtask

   task automatic check_reg(input logic [2:0] q, input logic [3:0] off);
      logic [31:0] expected;
      logic [31:0] actual;
      expected = expected_value(q, off);
      apb_transfer(1'b0, q, off, '0, actual);
      assert (actual == expected)
      else begin
         $display("[ERROR] prdata (queue %0d, offset %0d): expected %h, actual %h",
                  q, off, expected, actual);
         errors++;
      end
   endtask

   task automatic check_enable();
      assert (queue_enable == model_en)
      else begin
         $display("[ERROR] queue_enable: expected %h, actual %h", model_en, queue_enable);
         errors++;
      end
   endtask

   task automatic sweep_all();
      for (int q = 0; q < `OQ_NUM_QUEUES; q++) begin
         for (int r = 0; r < NUM_REGS; r++) begin
            check_reg(3'(q), 4'(r));
         end
      end
   endtask

   task automatic end_test(input string name);
      test_num++;
      $display("Test %0d %s: %0d errors", test_num, name, errors - test_errors);
      test_errors = errors;
   endtask

   // New bounds and counters, then initialize with the given enable bit
   task automatic init_queue(input logic [2:0] q, input logic en);
      logic [31:0] lo;
      logic [31:0] hi;
      lo = next_random() & 32'h0003_ffff;
      hi = lo + (next_random() & 32'h0000_ffff) + 1;
      write_reg(q, REG_ADDR_LO, lo);
      write_reg(q, REG_ADDR_HI, hi);
      write_reg(q, REG_PKTS_STORED, next_random() | 32'h1);
      write_reg(q, REG_PKTS_DROPPED, next_random() | 32'h1);
      write_reg(q, REG_CTRL, (32'h1 << `OQ_INIT_BIT) | 32'(en));
      check_enable();
      for (int r = 0; r < NUM_REGS; r++) begin
         check_reg(q, 4'(r));
      end
   endtask

   task automatic test_readback();
      logic [31:0] rnd;
      for (int i = 0; i < NUM_RAND; i++) begin
         rnd = next_random();
         write_reg(rnd[31:29], WRITABLE[rnd[7:0] % 5], next_random());
         check_reg(rnd[31:29], WRITABLE[rnd[7:0] % 5]);
      end
      for (int i = 0; i < NUM_RAND; i++) begin
         rnd = next_random();
         write_reg(rnd[31:29], READ_ONLY[rnd[7:0] % 5], next_random());
         check_reg(rnd[31:29], READ_ONLY[rnd[7:0] % 5]);
      end
   endtask

   task automatic test_unmapped();
      logic [31:0] rnd;
      for (int r = 11; r < 16; r++) begin
         rnd = next_random();
         check_reg(rnd[31:29], 4'(r));
         write_reg(rnd[31:29], 4'(r), next_random());
      end
      sweep_all();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      lcg_state   = 32'h01a4_f40a;
      errors      = 0;
      test_num    = 0;
      test_errors = 0;
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;

      // First transfer is held off until the walk is over
      model_defaults();
      check_reg(3'd0, REG_CTRL);
      check_enable();
      sweep_all();
      end_test("defaults after walk");

      test_readback();
      end_test("register readback");

      for (int i = 0; i < 2; i++) begin
         write_reg(3'(3 + 3 * i), REG_CTRL, 32'h0);
         check_enable();
         check_reg(3'(3 + 3 * i), REG_CTRL);
         write_reg(3'(3 + 3 * i), REG_CTRL, 32'h1);
         check_enable();
         check_reg(3'(3 + 3 * i), REG_CTRL);
      end
      end_test("queue enable");

      init_queue(3'd5, 1'b0);
      init_queue(3'd2, 1'b1);
      sweep_all();
      end_test("queue initialize");

      test_unmapped();
      end_test("unmapped offsets");

      errors += oq_regs_top_i.oq_regs_assertions_i.fail_count;
      $display("Tests: %0d, errors: %0d", test_num, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(LIMIT * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== hdl/oq_apb_slave.sv ====
// Output queue APB slave
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_apb_slave (
   input  logic                          clk,
   input  logic                          reset,

   // APB
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`OQ_APB_ADDR_WIDTH-1:0] paddr,
   input  logic [`OQ_DATA_WIDTH-1:0]     pwdata,
   output logic [`OQ_DATA_WIDTH-1:0]     prdata,
   output logic                          pready,

   // Request to the controller
   output oq_pkg::oq_host_req_t          host_req,
   input  logic                          host_done,
   input  logic [`OQ_DATA_WIDTH-1:0]     host_rdata
);

   import oq_pkg::*;

   logic      req_valid;
   logic      req_write;
   oq_queue_t req_queue;
   oq_reg_e   req_offset;
   oq_data_t  req_wdata;
   logic      setup_phase;

   // A setup phase always comes right before the first access cycle
   assign setup_phase = psel && !penable;

   // Request valid and wait-state control
   always_ff @(posedge clk) begin
      if (reset) begin
         req_valid <= 1'b0;
         pready    <= 1'b0;
      end else begin
         pready <= 1'b0;
         if (host_done) begin
            req_valid <= 1'b0;
            pready    <= 1'b1;
         end else if (setup_phase) begin
            req_valid <= 1'b1;
         end
      end
   end

   // Transfer fields and read data
   always_ff @(posedge clk) begin
      if (setup_phase) begin
         req_write  <= pwrite;
         req_queue  <= paddr[`OQ_QUEUE_MSB:`OQ_QUEUE_LSB];
         req_offset <= oq_reg_e'(paddr[`OQ_REG_MSB:`OQ_REG_LSB]);
         req_wdata  <= pwdata;
      end
      if (host_done) begin
         prdata <= host_rdata;
      end
   end

   assign host_req = '{valid:  req_valid,
                       write:  req_write,
                       queue:  req_queue,
                       offset: req_offset,
                       wdata:  req_wdata};

endmodule

// ==== hdl/oq_macros.svh ====
// Output queue register constants
`ifndef OQ_MACROS_SVH
`define OQ_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Sizes

// Number of output queues and width of a queue index
`define OQ_NUM_QUEUES        8
`define OQ_QUEUE_BITS        3

// Host register data width
`define OQ_DATA_WIDTH        32

// Word address into the packet buffer
`define OQ_SRAM_ADDR_WIDTH   19

// Register offset field width
`define OQ_REG_BITS          4

//////////////////////////////////////////////////////////////////////
// Defaults

// Buffer split evenly over the queues
`define OQ_QUEUE_WORDS       ((1 << `OQ_SRAM_ADDR_WIDTH) / `OQ_NUM_QUEUES)
`define OQ_DEFAULT_MAX_PKTS  32'h0000_8000
`define OQ_UNMAPPED_DATA     32'hdead_beef

//////////////////////////////////////////////////////////////////////
// Bit positions

// Control register bits
`define OQ_ENABLE_BIT        0
`define OQ_INIT_BIT          1

// APB address map: byte offset, register offset, queue index
`define OQ_APB_ADDR_WIDTH    9
`define OQ_REG_LSB           2
`define OQ_REG_MSB           5
`define OQ_QUEUE_LSB         6
`define OQ_QUEUE_MSB         8

`endif

// ==== hdl/oq_pkg.sv ====
// Output queue register types
`include "oq_macros.svh"

package oq_pkg;

   // Common vector types
   typedef logic [`OQ_DATA_WIDTH-1:0]      oq_data_t;
   typedef logic [`OQ_SRAM_ADDR_WIDTH-1:0] oq_sram_addr_t;
   typedef logic [`OQ_QUEUE_BITS-1:0]      oq_queue_t;

   // Controller states
   typedef enum logic [2:0] {
      ST_WALK,
      ST_IDLE,
      ST_ACCESS,
      ST_CLEAR,
      ST_PAUSE
   } oq_state_e;

   // Per-queue register offsets, 11 to 15 are unmapped
   typedef enum logic [`OQ_REG_BITS-1:0] {
      REG_CTRL         = 4'd0,
      REG_ADDR_HI      = 4'd1,
      REG_ADDR_LO      = 4'd2,
      REG_WR_ADDR      = 4'd3,
      REG_RD_ADDR      = 4'd4,
      REG_MAX_PKTS     = 4'd5,
      REG_PKTS_IN_Q    = 4'd6,
      REG_WORDS_IN_Q   = 4'd7,
      REG_WORDS_LEFT   = 4'd8,
      REG_PKTS_STORED  = 4'd9,
      REG_PKTS_DROPPED = 4'd10
   } oq_reg_e;

   // Register store operations
   typedef enum logic [1:0] {
      OP_READ,
      OP_WRITE,
      OP_DEFAULT,
      OP_CLEAR
   } oq_store_op_e;

   // Host request from the APB side
   typedef struct packed {
      logic      valid;
      logic      write;
      oq_queue_t queue;
      oq_reg_e   offset;
      oq_data_t  wdata;
   } oq_host_req_t;

   // Request into the register store
   typedef struct packed {
      logic         valid;
      oq_store_op_e op;
      oq_queue_t    queue;
      oq_reg_e      offset;
      oq_data_t     wdata;
   } oq_store_req_t;

   // Store answer, one cycle after the request
   typedef struct packed {
      logic     ack;
      oq_data_t rdata;
   } oq_store_rsp_t;

endpackage

// ==== hdl/oq_queue_regs.sv ====
// Output queue register store
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_queue_regs (
   input  logic                  clk,
   input  logic                  reset,
   input  oq_pkg::oq_store_req_t store_req,
   output oq_pkg::oq_store_rsp_t store_rsp
);

   import oq_pkg::*;

   // One entry per queue for each register
   oq_sram_addr_t addr_lo      [`OQ_NUM_QUEUES];
   oq_sram_addr_t addr_hi      [`OQ_NUM_QUEUES];
   oq_sram_addr_t wr_addr      [`OQ_NUM_QUEUES];
   oq_sram_addr_t rd_addr      [`OQ_NUM_QUEUES];
   oq_data_t      max_pkts     [`OQ_NUM_QUEUES];
   oq_data_t      pkts_in_q    [`OQ_NUM_QUEUES];
   oq_data_t      words_in_q   [`OQ_NUM_QUEUES];
   oq_data_t      words_left   [`OQ_NUM_QUEUES];
   oq_data_t      pkts_stored  [`OQ_NUM_QUEUES];
   oq_data_t      pkts_dropped [`OQ_NUM_QUEUES];

   oq_queue_t     q;
   oq_sram_addr_t def_lo;
   oq_sram_addr_t def_hi;
   oq_data_t      clr_words_left;
   oq_data_t      rd_data;
   logic          ack_q;
   oq_data_t      rdata_q;

   assign q = store_req.queue;

   // Default bounds split the buffer evenly by queue index
   assign def_lo = oq_sram_addr_t'(q) * oq_sram_addr_t'(`OQ_QUEUE_WORDS);
   assign def_hi = def_lo + oq_sram_addr_t'(`OQ_QUEUE_WORDS - 1);

   // Same rule as the reset default, inclusive bounds
   assign clr_words_left = oq_data_t'(addr_hi[q]) - oq_data_t'(addr_lo[q]) + 1'b1;

   //////////////////////////////////////////////////////////////////////
   // Register updates

   always_ff @(posedge clk) begin
      if (store_req.valid) begin
         case (store_req.op)
            OP_DEFAULT: begin
               addr_lo[q]      <= def_lo;
               addr_hi[q]      <= def_hi;
               wr_addr[q]      <= def_lo;
               rd_addr[q]      <= def_lo;
               max_pkts[q]     <= `OQ_DEFAULT_MAX_PKTS;
               words_left[q]   <= `OQ_QUEUE_WORDS;
               pkts_in_q[q]    <= '0;
               words_in_q[q]   <= '0;
               pkts_stored[q]  <= '0;
               pkts_dropped[q] <= '0;
            end
            OP_CLEAR: begin
               wr_addr[q]      <= addr_lo[q];
               rd_addr[q]      <= addr_lo[q];
               words_left[q]   <= clr_words_left;
               pkts_in_q[q]    <= '0;
               words_in_q[q]   <= '0;
               pkts_stored[q]  <= '0;
               pkts_dropped[q] <= '0;
            end
            OP_WRITE: begin
               // Pointers and occupancy are owned by the datapath
               case (store_req.offset)
                  REG_ADDR_HI:      addr_hi[q]      <= oq_sram_addr_t'(store_req.wdata);
                  REG_ADDR_LO:      addr_lo[q]      <= oq_sram_addr_t'(store_req.wdata);
                  REG_MAX_PKTS:     max_pkts[q]     <= store_req.wdata;
                  REG_PKTS_STORED:  pkts_stored[q]  <= store_req.wdata;
                  REG_PKTS_DROPPED: pkts_dropped[q] <= store_req.wdata;
                  default: ;
               endcase
            end
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read mux and acknowledge

   always_comb begin
      case (store_req.offset)
         REG_ADDR_HI:      rd_data = oq_data_t'(addr_hi[q]);
         REG_ADDR_LO:      rd_data = oq_data_t'(addr_lo[q]);
         REG_WR_ADDR:      rd_data = oq_data_t'(wr_addr[q]);
         REG_RD_ADDR:      rd_data = oq_data_t'(rd_addr[q]);
         REG_MAX_PKTS:     rd_data = max_pkts[q];
         REG_PKTS_IN_Q:    rd_data = pkts_in_q[q];
         REG_WORDS_IN_Q:   rd_data = words_in_q[q];
         REG_WORDS_LEFT:   rd_data = words_left[q];
         REG_PKTS_STORED:  rd_data = pkts_stored[q];
         REG_PKTS_DROPPED: rd_data = pkts_dropped[q];
         default:          rd_data = `OQ_UNMAPPED_DATA;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= store_req.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (store_req.valid) begin
         rdata_q <= (store_req.op == OP_READ) ? rd_data : '0;
      end
   end

   assign store_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

// ==== hdl/oq_regs_ctrl.sv ====
// Output queue register controller
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_regs_ctrl (
   input  logic                      clk,
   input  logic                      reset,

   // Host side
   input  oq_pkg::oq_host_req_t      host_req,
   output logic                      host_done,
   output logic [`OQ_DATA_WIDTH-1:0] host_rdata,

   // Register store
   output oq_pkg::oq_store_req_t     store_req,
   input  oq_pkg::oq_store_rsp_t     store_rsp,

   // To the packet store and remove logic
   output logic [`OQ_NUM_QUEUES-1:0] queue_enable
);

   import oq_pkg::*;

   localparam int LAST_QUEUE = `OQ_NUM_QUEUES - 1;

   oq_state_e state;
   oq_queue_t walk_cnt;
   logic      enable_held;

   logic      ctrl_access;
   logic      unmapped;
   logic      init_write;

   //////////////////////////////////////////////////////////////////////
   // Request decode

   assign ctrl_access = (host_req.offset == REG_CTRL);
   assign unmapped    = (host_req.offset > REG_PKTS_DROPPED);
   assign init_write  = host_req.write && ctrl_access && host_req.wdata[`OQ_INIT_BIT];

   //////////////////////////////////////////////////////////////////////
   // Main FSM

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= ST_WALK;
         walk_cnt     <= '0;
         queue_enable <= '0;
         enable_held  <= 1'b0;
      end else begin
         case (state)
            // One OP_DEFAULT per queue, then enable everything
            ST_WALK: begin
               if (store_rsp.ack) begin
                  walk_cnt <= walk_cnt + 1'b1;
                  if (int'(walk_cnt) == LAST_QUEUE) begin
                     state        <= ST_IDLE;
                     queue_enable <= '1;
                  end
               end
            end

            ST_IDLE: begin
               if (host_req.valid) begin
                  if (init_write) begin
                     // Queue stays disabled until the clear completes
                     queue_enable[host_req.queue] <= 1'b0;
                     enable_held                  <= host_req.wdata[`OQ_ENABLE_BIT];
                     state                        <= ST_CLEAR;
                  end else if (ctrl_access && host_req.write) begin
                     queue_enable[host_req.queue] <= host_req.wdata[`OQ_ENABLE_BIT];
                     state                        <= ST_PAUSE;
                  end else if (ctrl_access || unmapped) begin
                     state <= ST_PAUSE;
                  end else begin
                     state <= ST_ACCESS;
                  end
               end
            end

            ST_ACCESS: begin
               if (store_rsp.ack) begin
                  state <= ST_PAUSE;
               end
            end

            ST_CLEAR: begin
               if (store_rsp.ack) begin
                  queue_enable[host_req.queue] <= enable_held;
                  state                        <= ST_PAUSE;
               end
            end

            // Lets the slave drop its request before the next dispatch
            ST_PAUSE: begin
               state <= ST_IDLE;
            end

            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Store request, dropped in the ack cycle

   always_comb begin
      store_req        = '0;
      store_req.queue  = host_req.queue;
      store_req.offset = host_req.offset;
      store_req.wdata  = host_req.wdata;
      case (state)
         ST_WALK: begin
            store_req.valid = !store_rsp.ack;
            store_req.op    = OP_DEFAULT;
            store_req.queue = walk_cnt;
         end
         ST_ACCESS: begin
            store_req.valid = !store_rsp.ack;
            store_req.op    = host_req.write ? OP_WRITE : OP_READ;
         end
         ST_CLEAR: begin
            store_req.valid = !store_rsp.ack;
            store_req.op    = OP_CLEAR;
         end
         default: begin
            store_req.valid = 1'b0;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Host completion

   always_comb begin
      host_done  = 1'b0;
      host_rdata = '0;
      case (state)
         ST_IDLE: begin
            // Control and unmapped offsets are answered here
            if (host_req.valid && (ctrl_access || unmapped) && !init_write) begin
               host_done  = 1'b1;
               host_rdata = unmapped ? `OQ_UNMAPPED_DATA
                                     : oq_data_t'(queue_enable[host_req.queue]);
            end
         end
         ST_ACCESS: begin
            host_done  = store_rsp.ack;
            host_rdata = store_rsp.rdata;
         end
         ST_CLEAR: begin
            host_done = store_rsp.ack;
         end
         default: begin
            host_done = 1'b0;
         end
      endcase
   end

endmodule

// ==== hdl/oq_regs_top.sv ====
// Output queue register block
`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_regs_top (
   input  logic                          clk,
   input  logic                          reset,

   // APB
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`OQ_APB_ADDR_WIDTH-1:0] paddr,
   input  logic [`OQ_DATA_WIDTH-1:0]     pwdata,
   output logic [`OQ_DATA_WIDTH-1:0]     prdata,
   output logic                          pready,

   // Per-queue send enable
   output logic [`OQ_NUM_QUEUES-1:0]     queue_enable
);

   import oq_pkg::*;

   oq_host_req_t  host_req;
   logic          host_done;
   oq_data_t      host_rdata;
   oq_store_req_t store_req;
   oq_store_rsp_t store_rsp;

   oq_apb_slave oq_apb_slave_i (
      .clk        (clk),
      .reset      (reset),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .host_req   (host_req),
      .host_done  (host_done),
      .host_rdata (host_rdata)
   );

   oq_regs_ctrl oq_regs_ctrl_i (
      .clk          (clk),
      .reset        (reset),
      .host_req     (host_req),
      .host_done    (host_done),
      .host_rdata   (host_rdata),
      .store_req    (store_req),
      .store_rsp    (store_rsp),
      .queue_enable (queue_enable)
   );

   oq_queue_regs oq_queue_regs_i (
      .clk       (clk),
      .reset     (reset),
      .store_req (store_req),
      .store_rsp (store_rsp)
   );

endmodule

// ==== src.f ====
+incdir+hdl
hdl/oq_pkg.sv
hdl/oq_apb_slave.sv
hdl/oq_regs_ctrl.sv
hdl/oq_queue_regs.sv
hdl/oq_regs_top.sv
bench/oq_regs_assertions.sv
bench/oq_regs_tb.sv
